// File: all.f
source/isa_pkg.sv
source/rs_pkg.sv
source/rs_issue_select.sv
source/rs_entry_array.sv
source/reservation_station.sv
testbench/rs_sva.sv
testbench/rs_tb.sv

// File: testbench/rs_tb.sv
`timescale 1ns/1ns

module rs_tb;

    localparam int depth          = 8;
    localparam int num_alu        = 2;
    localparam int num_mem        = 1;
    localparam int count_width    = $clog2(depth + 1);
    localparam int max_dispatches = 200;
    localparam int random_cycles  = 400;
    localparam int drain_limit    = 200;

    // branch masks the dispatcher picks from
    localparam rs_pkg::br_mask_t mask_set [6] = '{4'b0000, 4'b0001, 4'b0010,
                                                 4'b0100, 4'b1000, 4'b0011};

    logic                             clock;
    logic                             reset;
    rs_pkg::rs_packet_t               dispatch;
    rs_pkg::cdb_packet_t              cdb;
    rs_pkg::br_mask_t                 br_mask;
    rs_pkg::br_task_e                 br_task;
    logic [num_alu-1:0]               alu_busy;
    logic [num_mem-1:0]               mem_busy;
    rs_pkg::rs_packet_t [num_alu-1:0] issued_alu;
    rs_pkg::rs_packet_t [num_mem-1:0] issued_mem;
    logic [count_width-1:0]           credit_return;

    // outstanding instructions by sequence id
    rs_pkg::rs_packet_t model_pkt [256];
    logic               model_live [256];

    integer     seed;
    int         errors;
    int         timeouts;
    int         credits;
    int         dispatched;
    int         returned;
    int         expected_credit;
    logic [7:0] next_seq;
    logic [7:0] bypass_seq;
    logic       bypass_seen;

    reservation_station #(
        .depth   (depth),
        .num_alu (num_alu),
        .num_mem (num_mem)
    ) dut_i (
        .clock         (clock),
        .reset         (reset),
        .dispatch      (dispatch),
        .cdb           (cdb),
        .br_mask       (br_mask),
        .br_task       (br_task),
        .alu_busy      (alu_busy),
        .mem_busy      (mem_busy),
        .issued_alu    (issued_alu),
        .issued_mem    (issued_mem),
        .credit_return (credit_return)
    );

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    function automatic int pick(input int n);
        return $unsigned($random(seed)) % n;
    endfunction

    function automatic rs_pkg::operand_t woken(input rs_pkg::operand_t op);
        rs_pkg::operand_t result;
        result = op;
        if (cdb.valid && cdb.tag == op.tag) begin
            result.ready = 1'b1;
        end
        return result;
    endfunction

    // held and of the port's kind with both sources woken and no squash this cycle
    function automatic logic may_issue(input logic [7:0] seq, input isa_pkg::fu_kind_e kind);
        rs_pkg::rs_packet_t p;
        logic               squashed_now;
        p            = model_pkt[seq];
        squashed_now = br_task == rs_pkg::BR_SQUASH && |(p.br_mask & br_mask);
        return model_live[seq] && p.kind == kind && p.src1.ready && p.src2.ready
               && !squashed_now;
    endfunction

    // every free unit gets work while ready instructions of its kind remain
    function automatic int expected_issues(input isa_pkg::fu_kind_e kind, input int free_units);
        int ready;
        ready = 0;
        for (int s = 0; s < 256; s++) begin
            if (may_issue(8'(s), kind)) begin
                ready++;
            end
        end
        return (ready < free_units) ? ready : free_units;
    endfunction

    function automatic int live_count();
        int n;
        n = 0;
        for (int s = 0; s < 256; s++) begin
            n += int'(model_live[s]);
        end
        return n;
    endfunction

    // moves the model past the coming edge and returns the number squashed
    function automatic int advance_model();
        int squashed;
        squashed = 0;
        for (int s = 0; s < 256; s++) begin
            if (model_live[s]) begin
                if (br_task == rs_pkg::BR_SQUASH && |(model_pkt[s].br_mask & br_mask)) begin
                    model_live[s] = 1'b0;
                    squashed++;
                end else begin
                    if (br_task == rs_pkg::BR_CLEAR) begin
                        model_pkt[s].br_mask = model_pkt[s].br_mask & ~br_mask;
                    end
                    model_pkt[s].src1 = woken(model_pkt[s].src1);
                    model_pkt[s].src2 = woken(model_pkt[s].src2);
                end
            end
        end
        if (dispatch.valid) begin
            model_pkt[dispatch.seq_id]      = dispatch;
            model_pkt[dispatch.seq_id].src1 = woken(dispatch.src1);
            model_pkt[dispatch.seq_id].src2 = woken(dispatch.src2);
            model_live[dispatch.seq_id]     = 1'b1;
        end
        return squashed;
    endfunction

    task automatic check_issue(input rs_pkg::rs_packet_t pkt, input isa_pkg::fu_kind_e kind,
                               input logic busy, input string port);
        logic legal;
        legal = may_issue(pkt.seq_id, kind);
        assert (!busy) else begin
            $display("%s carried a packet while its unit was busy", port);
            errors++;
        end
        assert (legal) else begin
            $display("%s issued sequence id %h, which may not issue now", port, pkt.seq_id);
            errors++;
        end
        if (legal) begin
            assert (pkt == model_pkt[pkt.seq_id]) else begin
                $display("** Error: %s = %h, expected %h", port, pkt, model_pkt[pkt.seq_id]);
                errors++;
            end
        end
        if (pkt.seq_id == bypass_seq) begin
            bypass_seen = 1'b1;
        end
        model_live[pkt.seq_id] = 1'b0;
    endtask

    always begin
        int alu_count;
        int mem_count;
        int alu_expected;
        int mem_expected;
        @(posedge clock);
        #60;
        if (!reset) begin
            alu_expected = expected_issues(isa_pkg::FU_ALU, num_alu - $countones(alu_busy));
            mem_expected = expected_issues(isa_pkg::FU_MEM, num_mem - $countones(mem_busy));
            assert (credit_return == count_width'(expected_credit)) else begin
                $display("** Error: credit_return = %h, expected %h",
                         credit_return, count_width'(expected_credit));
                errors++;
            end
            alu_count = 0;
            mem_count = 0;
            for (int u = 0; u < num_alu; u++) begin
                if (issued_alu[u].valid) begin
                    alu_count++;
                    check_issue(issued_alu[u], isa_pkg::FU_ALU, alu_busy[u],
                                $sformatf("issued_alu[%0d]", u));
                end
            end
            for (int u = 0; u < num_mem; u++) begin
                if (issued_mem[u].valid) begin
                    mem_count++;
                    check_issue(issued_mem[u], isa_pkg::FU_MEM, mem_busy[u],
                                $sformatf("issued_mem[%0d]", u));
                end
            end
            assert (alu_count == alu_expected && mem_count == mem_expected) else begin
                $display("Issued %0d ALU and %0d memory packets, expected %0d and %0d",
                         alu_count, mem_count, alu_expected, mem_expected);
                errors++;
            end
            expected_credit = alu_expected + mem_expected + advance_model();
        end
    end

    // dispatcher side of each cycle where credits come back
    task automatic next_cycle();
        @(posedge clock);
        #10;
        credits  += int'(credit_return);
        returned += int'(credit_return);
    endtask

    task automatic drive_random();
        rs_pkg::rs_packet_t pkt;
        pkt = '0;
        if (credits > 0 && dispatched < max_dispatches && pick(4) != 0) begin
            pkt.valid = 1'b1;
            pkt.kind  = isa_pkg::fu_kind_e'(pick(2));
            if (pkt.kind == isa_pkg::FU_ALU) begin
                pkt.opcode = isa_pkg::opcode_e'(pick(4));
            end else begin
                pkt.opcode = isa_pkg::opcode_e'(4 + pick(2));
            end
            pkt.dest       = isa_pkg::phys_tag_t'(pick(64));
            pkt.src1.tag   = isa_pkg::phys_tag_t'(pick(16));
            pkt.src1.ready = pick(3) == 0;
            pkt.src2.tag   = isa_pkg::phys_tag_t'(pick(16));
            pkt.src2.ready = pick(3) == 0;
            pkt.br_mask    = mask_set[pick(6)];
            pkt.seq_id     = next_seq;
            next_seq++;
            dispatched++;
            credits--;
        end
        dispatch  = pkt;
        cdb.valid = pick(2) == 0;
        cdb.tag   = isa_pkg::phys_tag_t'(pick(16));
        case (pick(16))
            0:       br_task = rs_pkg::BR_SQUASH;
            1:       br_task = rs_pkg::BR_CLEAR;
            default: br_task = rs_pkg::BR_NONE;
        endcase
        br_mask  = rs_pkg::br_mask_t'(1 << pick(4));
        alu_busy = num_alu'(pick(4));
        mem_busy = num_mem'(pick(2));
    endtask

    task automatic drive_idle();
        dispatch = '0;
        cdb      = '0;
        br_mask  = '0;
        br_task  = rs_pkg::BR_NONE;
        alu_busy = '0;
        mem_busy = '0;
    endtask

    // cdb walks the source tag range until everything has left
    task automatic drain();
        int cycles;
        cycles = 0;
        while ((live_count() != 0 || credits != depth) && cycles < drain_limit) begin
            next_cycle();
            drive_idle();
            cdb.valid = 1'b1;
            cdb.tag   = isa_pkg::phys_tag_t'(cycles % 16);
            cycles++;
        end
        if (live_count() != 0 || credits != depth) begin
            $display("Drain timed out with %0d instructions outstanding and %0d credits",
                     live_count(), credits);
            timeouts++;
        end
    endtask

    // source tag broadcast in the dispatch cycle so the issue is due one cycle later
    task automatic check_bypass();
        rs_pkg::rs_packet_t pkt;
        int                 cycles;
        next_cycle();
        pkt          = '0;
        pkt.valid    = 1'b1;
        pkt.kind     = isa_pkg::FU_ALU;
        pkt.opcode   = isa_pkg::OP_ADD;
        pkt.dest     = 6'd33;
        pkt.src1.tag = 6'd40;
        pkt.src2.tag = 6'd40;
        pkt.seq_id   = next_seq;
        bypass_seq   = next_seq;
        next_seq++;
        dispatched++;
        credits--;
        drive_idle();
        dispatch  = pkt;
        cdb.valid = 1'b1;
        cdb.tag   = 6'd40;
        next_cycle();
        drive_idle();
        cycles = 0;
        while (!bypass_seen && cycles < 1) begin
            next_cycle();
            cycles++;
        end
        if (!bypass_seen) begin
            $display("Instruction woken by bypass did not issue in the cycle after dispatch");
            timeouts++;
        end
    endtask

    initial begin
        seed            = 95;
        errors          = 0;
        timeouts        = 0;
        credits         = depth;
        dispatched      = 0;
        returned        = 0;
        expected_credit = 0;
        next_seq        = '0;
        bypass_seq      = 8'hff;
        bypass_seen     = 1'b0;
        for (int s = 0; s < 256; s++) begin
            model_pkt[s]  = '0;
            model_live[s] = 1'b0;
        end
        reset = 1'b1;
        drive_idle();
        repeat (2) @(posedge clock);
        #10;
        reset = 1'b0;
        for (int c = 0; c < random_cycles; c++) begin
            next_cycle();
            drive_random();
        end
        drain();
        check_bypass();
        drain();
        assert (returned == dispatched && credits == depth) else begin
            $display("Returned %0d credits for %0d dispatches, dispatcher holds %0d",
                     returned, dispatched, credits);
            errors++;
        end
        $display("Dispatched %0d, check errors %0d, timeouts %0d",
                 dispatched, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// File: testbench/rs_sva.sv
`timescale 1ns/1ns

module rs_sva #(
    parameter int depth   = 8,
    parameter int num_alu = 2,
    parameter int num_mem = 1
) (
    input logic                               clock,
    input logic                               reset,
    input rs_pkg::rs_packet_t                 dispatch,
    input logic [num_alu-1:0][depth-1:0]      alu_grant_bus,
    input logic [num_mem-1:0][depth-1:0]      mem_grant_bus,
    input rs_pkg::rs_packet_t [num_alu-1:0]   issued_alu,
    input rs_pkg::rs_packet_t [num_mem-1:0]   issued_mem,
    input logic [$clog2(depth+1)-1:0]         credit_return
);

    // slots dispatched and not yet credited back
    int   held;
    logic double_grant;
    logic any_issue;

    always_ff @(posedge clock) begin
        if (reset) begin
            held <= 0;
        end else begin
            held <= held + int'(dispatch.valid) - int'(credit_return);
        end
    end

    always_comb begin
        int hits;
        double_grant = 1'b0;
        for (int s = 0; s < depth; s++) begin
            hits = 0;
            for (int u = 0; u < num_alu; u++) begin
                hits += int'(alu_grant_bus[u][s]);
            end
            for (int u = 0; u < num_mem; u++) begin
                hits += int'(mem_grant_bus[u][s]);
            end
            double_grant = double_grant | (hits > 1);
        end
    end

    always_comb begin
        any_issue = 1'b0;
        for (int u = 0; u < num_alu; u++) begin
            any_issue = any_issue | issued_alu[u].valid;
        end
        for (int u = 0; u < num_mem; u++) begin
            any_issue = any_issue | issued_mem[u].valid;
        end
    end

    unique_grant: assert property (@(posedge clock) disable iff (reset) !double_grant)
        else $error("a slot was granted to two units in one cycle");

    credit_bound: assert property (@(posedge clock) disable iff (reset)
        int'(credit_return) <= held)
        else $error("dispatcher credit balance rose above the station depth");

    dispatch_room: assert property (@(posedge clock) disable iff (reset)
        dispatch.valid |-> held - int'(credit_return) < depth)
        else $error("dispatch sent while the station had no free slot");

    reset_state: assert property (@(posedge clock) reset |=> !any_issue && credit_return == '0)
        else $error("issue ports or credit_return not cleared by reset");

endmodule

bind reservation_station rs_sva #(
    .depth   (depth),
    .num_alu (num_alu),
    .num_mem (num_mem)
) sva_i (.*);

// File: source/reservation_station.sv
`timescale 1ns/1ns

module reservation_station #(
    parameter int depth   = 8,
    parameter int num_alu = 2,
    parameter int num_mem = 1
) (
    input  logic                               clock,
    input  logic                               reset,

    input  rs_pkg::rs_packet_t                 dispatch,
    input  rs_pkg::cdb_packet_t                cdb,
    input  rs_pkg::br_mask_t                   br_mask,
    input  rs_pkg::br_task_e                   br_task,

    // per-unit busy bits from the function units
    input  logic [num_alu-1:0]                 alu_busy,
    input  logic [num_mem-1:0]                 mem_busy,

    output rs_pkg::rs_packet_t [num_alu-1:0]   issued_alu,
    output rs_pkg::rs_packet_t [num_mem-1:0]   issued_mem,
    output logic [$clog2(depth+1)-1:0]         credit_return
);

    logic [depth-1:0]               alu_request;
    logic [depth-1:0]               mem_request;
    logic [num_alu-1:0][depth-1:0]  alu_grant_bus;
    logic [num_mem-1:0][depth-1:0]  mem_grant_bus;
    logic [depth-1:0]               alu_granted;
    logic [depth-1:0]               mem_granted;

    rs_entry_array #(
        .depth   (depth),
        .num_alu (num_alu),
        .num_mem (num_mem)
    ) entries_i (
        .clock         (clock),
        .reset         (reset),
        .dispatch      (dispatch),
        .cdb           (cdb),
        .br_mask       (br_mask),
        .br_task       (br_task),
        .alu_request   (alu_request),
        .mem_request   (mem_request),
        .alu_grant_bus (alu_grant_bus),
        .alu_granted   (alu_granted),
        .mem_grant_bus (mem_grant_bus),
        .mem_granted   (mem_granted),
        .issued_alu    (issued_alu),
        .issued_mem    (issued_mem),
        .credit_return (credit_return)
    );

    rs_issue_select #(
        .depth     (depth),
        .num_units (num_alu)
    ) alu_select (
        .request   (alu_request),
        .unit_busy (alu_busy),
        .grant_bus (alu_grant_bus),
        .granted   (alu_granted)
    );

    rs_issue_select #(
        .depth     (depth),
        .num_units (num_mem)
    ) mem_select (
        .request   (mem_request),
        .unit_busy (mem_busy),
        .grant_bus (mem_grant_bus),
        .granted   (mem_granted)
    );

endmodule

// File: source/rs_entry_array.sv
`timescale 1ns/1ns

module rs_entry_array #(
    parameter int depth   = 8,
    parameter int num_alu = 2,
    parameter int num_mem = 1
) (
    input  logic                               clock,
    input  logic                               reset,

    input  rs_pkg::rs_packet_t                 dispatch,
    input  rs_pkg::cdb_packet_t                cdb,
    input  rs_pkg::br_mask_t                   br_mask,
    input  rs_pkg::br_task_e                   br_task,

    output logic [depth-1:0]                   alu_request,
    output logic [depth-1:0]                   mem_request,

    input  logic [num_alu-1:0][depth-1:0]      alu_grant_bus,
    input  logic [depth-1:0]                   alu_granted,
    input  logic [num_mem-1:0][depth-1:0]      mem_grant_bus,
    input  logic [depth-1:0]                   mem_granted,

    output rs_pkg::rs_packet_t [num_alu-1:0]   issued_alu,
    output rs_pkg::rs_packet_t [num_mem-1:0]   issued_mem,
    output logic [$clog2(depth+1)-1:0]         credit_return
);

    localparam int count_width = $clog2(depth + 1);

    rs_pkg::rs_packet_t [depth-1:0] entries;
    rs_pkg::rs_packet_t [depth-1:0] next_entries;
    rs_pkg::rs_packet_t             incoming;

    logic [depth-1:0]       squashed;
    logic [depth-1:0]       freed;
    logic [depth-1:0]       alloc_slot;
    logic [count_width-1:0] freed_count;

    // marks an operand ready when the cdb carries its tag
    function automatic rs_pkg::operand_t wake(input rs_pkg::operand_t operand,
                                              input rs_pkg::cdb_packet_t bus);
        rs_pkg::operand_t result;
        result = operand;
        if (bus.valid && bus.tag == operand.tag) begin
            result.ready = 1'b1;
        end
        return result;
    endfunction

    // entries hit by a squash this cycle
    always_comb begin
        for (int i = 0; i < depth; i++) begin
            squashed[i] = entries[i].valid && br_task == rs_pkg::BR_SQUASH
                          && |(entries[i].br_mask & br_mask);
        end
    end

    // a squashed entry is dropped from the requests
    // so it is never granted in the cycle it is squashed
    always_comb begin
        logic operands_ready;
        for (int i = 0; i < depth; i++) begin
            operands_ready = entries[i].valid && entries[i].src1.ready
                             && entries[i].src2.ready && !squashed[i];
            alu_request[i] = operands_ready && entries[i].kind == isa_pkg::FU_ALU;
            mem_request[i] = operands_ready && entries[i].kind == isa_pkg::FU_MEM;
        end
    end

    assign freed = squashed | alu_granted | mem_granted;

    // lowest empty slot takes the next dispatch
    always_comb begin
        logic found;
        found      = 1'b0;
        alloc_slot = '0;
        for (int i = 0; i < depth; i++) begin
            if (!entries[i].valid && !found) begin
                alloc_slot[i] = 1'b1;
                found         = 1'b1;
            end
        end
    end

    // cdb bypass for the packet being written
    always_comb begin
        incoming      = dispatch;
        incoming.src1 = wake(dispatch.src1, cdb);
        incoming.src2 = wake(dispatch.src2, cdb);
    end

    always_comb begin
        next_entries = entries;
        for (int i = 0; i < depth; i++) begin
            next_entries[i].src1 = wake(entries[i].src1, cdb);
            next_entries[i].src2 = wake(entries[i].src2, cdb);
            if (br_task == rs_pkg::BR_CLEAR) begin
                next_entries[i].br_mask = entries[i].br_mask & ~br_mask;
            end
            if (freed[i]) begin
                next_entries[i].valid = 1'b0;
            end
            if (dispatch.valid && alloc_slot[i]) begin
                next_entries[i] = incoming;
            end
        end
    end

    // one credit per slot freed this cycle
    always_comb begin
        freed_count = '0;
        for (int i = 0; i < depth; i++) begin
            freed_count = freed_count + count_width'(freed[i]);
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < depth; i++) begin
                entries[i].valid <= 1'b0;
            end
            credit_return <= '0;
        end else begin
            entries       <= next_entries;
            credit_return <= freed_count;
        end
    end

    // grants are one-hot per unit and an idle unit sees all zeros
    always_comb begin
        issued_alu = '0;
        for (int u = 0; u < num_alu; u++) begin
            for (int j = 0; j < depth; j++) begin
                if (alu_grant_bus[u][j]) begin
                    issued_alu[u] = entries[j];
                end
            end
        end
    end

    always_comb begin
        issued_mem = '0;
        for (int u = 0; u < num_mem; u++) begin
            for (int j = 0; j < depth; j++) begin
                if (mem_grant_bus[u][j]) begin
                    issued_mem[u] = entries[j];
                end
            end
        end
    end

endmodule

// File: source/rs_issue_select.sv
`timescale 1ns/1ns

module rs_issue_select #(
    parameter int depth     = 8,
    parameter int num_units = 2
) (
    input  logic [depth-1:0]                 request,
    input  logic [num_units-1:0]             unit_busy,
    output logic [num_units-1:0][depth-1:0]  grant_bus,
    output logic [depth-1:0]                 granted
);

    // isolates the lowest set bit of a vector
    function automatic logic [depth-1:0] lowest_one(input logic [depth-1:0] bits);
        logic [depth-1:0] negated;
        negated = ~bits + 1'b1;
        return bits & negated;
    endfunction

    // free units in index order each take the lowest remaining request
    // and clear it so no slot is picked twice
    always_comb begin
        logic [depth-1:0] remaining;
        remaining = request;
        for (int u = 0; u < num_units; u++) begin
            grant_bus[u] = '0;
            if (!unit_busy[u]) begin
                grant_bus[u] = lowest_one(remaining);
                remaining    = remaining & ~grant_bus[u];
            end
        end
    end

    // slots leaving this cycle, used by the array to free them
    always_comb begin
        granted = '0;
        for (int u = 0; u < num_units; u++) begin
            granted = granted | grant_bus[u];
        end
    end

endmodule

// File: source/rs_pkg.sv
package rs_pkg;

    localparam int br_mask_width = 4;
    localparam int seq_id_width  = 8;

    // one bit per unresolved branch
    typedef logic [br_mask_width-1:0] br_mask_t;

    typedef logic [seq_id_width-1:0] seq_id_t;

    typedef enum logic [1:0] {
        BR_NONE   = 2'd0,
        BR_SQUASH = 2'd1,
        BR_CLEAR  = 2'd2
    } br_task_e;

    // source operand: tag plus ready bit
    typedef struct packed {
        isa_pkg::phys_tag_t tag;
        logic               ready;
    } operand_t;

    // dispatch packet, also what leaves on the issue ports
    typedef struct packed {
        logic               valid;
        isa_pkg::fu_kind_e  kind;
        isa_pkg::opcode_e   opcode;
        isa_pkg::phys_tag_t dest;
        operand_t           src1;
        operand_t           src2;
        br_mask_t           br_mask;
        seq_id_t            seq_id;
    } rs_packet_t;

    // one common data bus broadcast
    typedef struct packed {
        logic               valid;
        isa_pkg::phys_tag_t tag;
    } cdb_packet_t;

endpackage

// File: source/isa_pkg.sv
package isa_pkg;

    // which group of function units an instruction goes to
    typedef enum logic {
        FU_ALU = 1'b0,
        FU_MEM = 1'b1
    } fu_kind_e;

    // operation code, carried through to the unit unchanged
    typedef enum logic [2:0] {
        OP_ADD   = 3'd0,
        OP_SUB   = 3'd1,
        OP_AND   = 3'd2,
        OP_OR    = 3'd3,
        OP_LOAD  = 3'd4,
        OP_STORE = 3'd5
    } opcode_e;

    localparam int phys_tag_width = 6;

    // physical register tag after renaming
    typedef logic [phys_tag_width-1:0] phys_tag_t;

endpackage
